// File: rtl/ooo_buffer_pkg.sv
package ooo_buffer_pkg;

  // Width of one stored data word
  localparam int DATA_WIDTH = 8;

  // Number of slots in the buffer
  localparam int DEPTH = 8;

  // Enough bits to address every slot
  localparam int INDEX_WIDTH = $clog2(DEPTH);

  // The count must reach DEPTH itself, so one more value than the index
  localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

  // A word as held in one slot
  typedef logic [DATA_WIDTH-1:0] data_t;

  // Address of a slot, used on both the write and the read side
  typedef logic [INDEX_WIDTH-1:0] index_t;

  // Number of occupied slots, from 0 up to DEPTH
  typedef logic [COUNT_WIDTH-1:0] count_t;

endpackage

// File: rtl/ooo_ctrl_pkg.sv
package ooo_ctrl_pkg;

  // Encoding width of the flush state machine
  localparam int FLUSH_STATE_WIDTH = 1;

  // The flush machine either waits for a strobe or walks the slots
  // FLUSH_WALK lasts one cycle per slot and clears the visited slot
  typedef enum logic [FLUSH_STATE_WIDTH-1:0] {
    FLUSH_IDLE = 1'b0,
    FLUSH_WALK = 1'b1
  } flush_state_t;

endpackage

// File: rtl/ooo_slot_if.sv
`timescale 1ns/1ps

interface ooo_slot_if;

  import ooo_buffer_pkg::*;

  // Write side, the index is chosen by the store and returned in the same cycle
  logic   write_enable;
  data_t  write_data;
  index_t write_index;

  // Read side, data is combinational from read_index
  logic   read_enable;
  logic   read_clear;
  index_t read_index;
  data_t  read_data;

  // Valid bit of the slot currently addressed by read_index
  logic   slot_valid;

  // Flow-control wrapper side
  modport ctrl (
    output write_enable,
    output write_data,
    input  write_index,
    output read_enable,
    output read_clear,
    output read_index,
    input  read_data,
    input  slot_valid
  );

  // Slot store side
  modport store (
    input  write_enable,
    input  write_data,
    output write_index,
    input  read_enable,
    input  read_clear,
    input  read_index,
    output read_data,
    output slot_valid
  );

endinterface

// File: rtl/out_of_order_buffer.sv
`timescale 1ns/1ps

module out_of_order_buffer (
  input logic     clock,
  input logic     rst,
  ooo_slot_if.store slot
);

  import ooo_buffer_pkg::*;

  // Storage array, one word per slot
  data_t mem [DEPTH];

  // One bit per slot, set while the slot holds a word
  logic [DEPTH-1:0] valid;

  // Lowest-numbered slot whose valid bit is clear
  index_t first_free;

  // A clear only acts on a slot that is actually occupied
  logic clear_hit;

  // Priority encoder, scanning downwards so the lowest free index wins
  // When every slot is taken the result is 0, but no write is accepted then
  always_comb begin
    first_free = '0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (!valid[i]) begin
        first_free = index_t'(i);
      end
    end
  end

  assign slot.write_index = first_free;

  // Reads are fully combinational from the addressed slot
  assign slot.read_data  = mem[slot.read_index];
  assign slot.slot_valid = valid[slot.read_index];

  assign clear_hit = slot.read_enable && slot.read_clear && valid[slot.read_index];

  // The word lands in the slot picked this cycle and is readable from the next one
  always_ff @(posedge clock) begin
    if (slot.write_enable) begin
      mem[first_free] <= slot.write_data;
    end
  end

  // The written slot is free now and the cleared slot is valid now,
  // so the two updates never address the same bit
  always_ff @(posedge clock) begin
    if (rst) begin
      valid <= '0;
    end else begin
      if (slot.write_enable) begin
        valid[first_free] <= 1'b1;
      end
      if (clear_hit) begin
        valid[slot.read_index] <= 1'b0;
      end
    end
  end

  // The wrapper gates writes with the counter's full flag, which must agree
  // with the valid bits held here
  assert property (@(posedge clock) disable iff (rst)
    slot.write_enable |-> !(&valid))
    else $error("write accepted while every slot is occupied");

endmodule

// File: rtl/valid_ready_out_of_order_buffer.sv
`timescale 1ns/1ps

module valid_ready_out_of_order_buffer (
  input  logic                   clock,
  input  logic                   rst,
  input  logic                   write_valid,
  input  ooo_buffer_pkg::data_t  write_data,
  output ooo_buffer_pkg::index_t write_index,
  output logic                   write_ready,
  input  logic                   read_valid,
  input  logic                   read_clear,
  input  ooo_buffer_pkg::index_t read_index,
  output ooo_buffer_pkg::data_t  read_data,
  output logic                   read_ready,
  output logic                   read_error,
  input  logic                   full,
  input  logic                   flush_busy,
  input  logic                   flush_clear,
  input  ooo_buffer_pkg::index_t flush_index,
  output logic                   inc,
  output logic                   dec,
  ooo_slot_if.ctrl               slot
);

  import ooo_buffer_pkg::*;

  // Writes stall on a full buffer and for the whole flush walk
  assign write_ready = !full && !flush_busy;

  // slot_valid follows the external read_index outside a flush
  assign read_ready = slot.slot_valid && !flush_busy;
  assign read_error = read_valid && !slot.slot_valid && !flush_busy;

  assign slot.write_enable = write_valid && write_ready;
  assign slot.write_data   = write_data;
  assign write_index       = slot.write_index;

  // During a flush the walk takes over the read side and clears each slot
  assign slot.read_index  = flush_busy ? flush_index : read_index;
  assign slot.read_enable = flush_busy ? flush_clear : (read_valid && read_ready);
  assign slot.read_clear  = flush_busy ? flush_clear : read_clear;
  assign read_data        = slot.read_data;

  // Only slots that were really occupied lower the count
  assign inc = slot.write_enable;
  assign dec = slot.read_enable && slot.read_clear && slot.slot_valid;

  // The counter would drift if a write slipped in while the walk clears slots
  assert property (@(posedge clock) disable iff (rst)
    !(inc && flush_clear))
    else $error("write accepted during a flush");

endmodule

// File: rtl/occupancy_counter.sv
`timescale 1ns/1ps

module occupancy_counter (
  input  logic                   clock,
  input  logic                   rst,
  input  logic                   inc,
  input  logic                   dec,
  output ooo_buffer_pkg::count_t count,
  output logic                   full,
  output logic                   empty
);

  import ooo_buffer_pkg::*;

  count_t count_next;

  // A write and a clear in the same cycle cancel out
  always_comb begin
    count_next = count;
    if (inc && !dec) begin
      count_next = count + count_t'(1);
    end else if (dec && !inc) begin
      count_next = count - count_t'(1);
    end
  end

  // Flags come from the next count so they line up with the count register
  always_ff @(posedge clock) begin
    if (rst) begin
      count <= '0;
      full  <= 1'b0;
      empty <= 1'b1;
    end else begin
      count <= count_next;
      full  <= (count_next == count_t'(DEPTH));
      empty <= (count_next == '0);
    end
  end

  // The wrapper's ready logic must keep the counter inside its range
  assert property (@(posedge clock) disable iff (rst)
    !(inc && count == count_t'(DEPTH)))
    else $error("occupancy increment at full");

  assert property (@(posedge clock) disable iff (rst)
    !(dec && count == '0))
    else $error("occupancy decrement at zero");

endmodule

// File: rtl/flush_controller.sv
`timescale 1ns/1ps

module flush_controller (
  input  logic                   clock,
  input  logic                   rst,
  input  logic                   flush,
  output logic                   flush_busy,
  output logic                   flush_clear,
  output ooo_buffer_pkg::index_t flush_index
);

  import ooo_buffer_pkg::*;
  import ooo_ctrl_pkg::*;

  flush_state_t state;
  index_t       walk_index;

  // The last slot of the walk, after which the machine goes back to idle
  logic last_slot;

  assign last_slot = (walk_index == index_t'(DEPTH - 1));

  // A strobe while walking is ignored, the walk simply runs to its end
  always_ff @(posedge clock) begin
    if (rst) begin
      state      <= FLUSH_IDLE;
      walk_index <= '0;
    end else begin
      case (state)
        FLUSH_IDLE: begin
          if (flush) begin
            state      <= FLUSH_WALK;
            walk_index <= '0;
          end
        end
        FLUSH_WALK: begin
          walk_index <= walk_index + index_t'(1);
          if (last_slot) begin
            state <= FLUSH_IDLE;
          end
        end
        default: begin
          state <= FLUSH_IDLE;
        end
      endcase
    end
  end

  // One slot is visited per cycle, so busy lasts exactly DEPTH cycles
  assign flush_busy  = (state == FLUSH_WALK);
  assign flush_clear = (state == FLUSH_WALK);
  assign flush_index = walk_index;

  // Every walk starts at slot 0 and covers all slots before it stops
  assert property (@(posedge clock) disable iff (rst)
    $rose(flush_clear) |-> flush_index == '0 ##0 flush_clear [*DEPTH] ##1 !flush_clear)
    else $error("flush walk did not cover every slot exactly once");

endmodule

// File: rtl/ooo_buffer_top.sv
`timescale 1ns/1ps

module ooo_buffer_top (
  input  logic                   clock,
  input  logic                   rst,
  input  logic                   write_valid,
  input  ooo_buffer_pkg::data_t  write_data,
  output ooo_buffer_pkg::index_t write_index,
  output logic                   write_ready,
  input  logic                   read_valid,
  input  logic                   read_clear,
  input  ooo_buffer_pkg::index_t read_index,
  output ooo_buffer_pkg::data_t  read_data,
  output logic                   read_ready,
  output logic                   read_error,
  input  logic                   flush,
  output logic                   flush_busy,
  output ooo_buffer_pkg::count_t count,
  output logic                   full,
  output logic                   empty
);

  import ooo_buffer_pkg::*;

  // Walk signals from the flush machine into the wrapper
  logic   flush_clear;
  index_t flush_index;

  // Occupancy updates from the wrapper
  logic inc;
  logic dec;

  // Storage access port between wrapper and store
  ooo_slot_if slot_bus ();

  valid_ready_out_of_order_buffer flow_ctrl (
    .clock       (clock),
    .rst         (rst),
    .write_valid (write_valid),
    .write_data  (write_data),
    .write_index (write_index),
    .write_ready (write_ready),
    .read_valid  (read_valid),
    .read_clear  (read_clear),
    .read_index  (read_index),
    .read_data   (read_data),
    .read_ready  (read_ready),
    .read_error  (read_error),
    .full        (full),
    .flush_busy  (flush_busy),
    .flush_clear (flush_clear),
    .flush_index (flush_index),
    .inc         (inc),
    .dec         (dec),
    .slot        (slot_bus.ctrl)
  );

  out_of_order_buffer store (
    .clock (clock),
    .rst   (rst),
    .slot  (slot_bus.store)
  );

  occupancy_counter occupancy (
    .clock (clock),
    .rst   (rst),
    .inc   (inc),
    .dec   (dec),
    .count (count),
    .full  (full),
    .empty (empty)
  );

  flush_controller flusher (
    .clock       (clock),
    .rst         (rst),
    .flush       (flush),
    .flush_busy  (flush_busy),
    .flush_clear (flush_clear),
    .flush_index (flush_index)
  );

endmodule

// File: testbench/ooo_buffer_tb.sv
`timescale 1ns/1ps

module ooo_buffer_tb;

  import ooo_buffer_pkg::*;

  // Upper bound on any single wait for a handshake or for the flush to end
  localparam int TIMEOUT_CYCLES = 50;

  logic   clock;
  logic   rst;
  logic   write_valid;
  data_t  write_data;
  index_t write_index;
  logic   write_ready;
  logic   read_valid;
  logic   read_clear;
  index_t read_index;
  data_t  read_data;
  logic   read_ready;
  logic   read_error;
  logic   flush;
  logic   flush_busy;
  count_t count;
  logic   full;
  logic   empty;

  // Reference model of which slots hold a word and what they hold
  logic   model_valid [DEPTH];
  data_t  model_data [DEPTH];
  count_t model_count;

  int     mismatch_count;
  int     timeout_count;
  integer seed;

  // Testbench signals carry the same names as the top-level ports
  ooo_buffer_top uut (.*);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  task automatic check_data(input string name, input data_t expected, input data_t actual);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s expected %0h got %0h", $time, name, expected, actual);
      mismatch_count++;
    end
  endtask

  task automatic check_index(input string name, input index_t expected, input index_t actual);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s expected %0d got %0d", $time, name, expected, actual);
      mismatch_count++;
    end
  endtask

  task automatic check_count(input string name, input count_t expected, input count_t actual);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s expected %0d got %0d", $time, name, expected, actual);
      mismatch_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s expected %b got %b", $time, name, expected, actual);
      mismatch_count++;
    end
  endtask

  // The first free slot counting up from index 0
  function automatic index_t lowest_free();
    for (int i = 0; i < DEPTH; i++) begin
      if (!model_valid[i]) begin
        return index_t'(i);
      end
    end
    return '0;
  endfunction

  // Every task starts and ends 1 ns after a rising edge and checks at 2 ns
  task automatic write_word(input data_t value);
    int     waited;
    index_t expected;
    write_valid = 1'b1;
    write_data  = value;
    waited      = 0;
    #1;
    while (!write_ready && waited < TIMEOUT_CYCLES) begin
      @(posedge clock);
      #2;
      waited++;
    end
    if (!write_ready) begin
      $display("Timeout: write_ready never rose for a pending write at %0t", $time);
      timeout_count++;
    end else begin
      expected = lowest_free();
      check_index("write_index", expected, write_index);
      model_valid[expected] = 1'b1;
      model_data[expected]  = value;
      model_count++;
    end
    @(posedge clock);
    #1;
    write_valid = 1'b0;
  endtask

  task automatic read_slot(input index_t idx, input logic clear);
    int waited;
    read_valid = 1'b1;
    read_index = idx;
    read_clear = clear;
    waited     = 0;
    #1;
    while (!read_ready && waited < TIMEOUT_CYCLES) begin
      @(posedge clock);
      #2;
      waited++;
    end
    if (!read_ready) begin
      $display("Timeout: read_ready never rose for slot %0d at %0t", idx, $time);
      timeout_count++;
    end else begin
      check_data("read_data", model_data[idx], read_data);
      check_flag("read_error", 1'b0, read_error);
      if (clear) begin
        model_valid[idx] = 1'b0;
        model_count--;
      end
    end
    @(posedge clock);
    #1;
    read_valid = 1'b0;
    read_clear = 1'b0;
  endtask

  // A clear is requested too, to show that a refused read changes nothing
  task automatic read_free_slot(input index_t idx);
    read_valid = 1'b1;
    read_index = idx;
    read_clear = 1'b1;
    #1;
    check_flag("read_ready", 1'b0, read_ready);
    check_flag("read_error", 1'b1, read_error);
    @(posedge clock);
    #1;
    read_valid = 1'b0;
    read_clear = 1'b0;
    check_count("count", model_count, count);
  endtask

  // The slot being cleared is still occupied this cycle and must not be offered
  task automatic write_and_clear(input data_t value, input index_t idx);
    int     waited;
    index_t expected;
    write_valid = 1'b1;
    write_data  = value;
    read_valid  = 1'b1;
    read_index  = idx;
    read_clear  = 1'b1;
    waited      = 0;
    #1;
    while (!(write_ready && read_ready) && waited < TIMEOUT_CYCLES) begin
      @(posedge clock);
      #2;
      waited++;
    end
    if (!(write_ready && read_ready)) begin
      $display("Timeout: combined write and clear of slot %0d never accepted", idx);
      timeout_count++;
    end else begin
      expected = lowest_free();
      check_index("write_index", expected, write_index);
      check_data("read_data", model_data[idx], read_data);
      model_valid[expected] = 1'b1;
      model_data[expected]  = value;
      model_valid[idx]      = 1'b0;
    end
    @(posedge clock);
    #1;
    write_valid = 1'b0;
    read_valid  = 1'b0;
    read_clear  = 1'b0;
  endtask

  // Indices come back 0 upwards since the model starts empty
  task automatic test_fill();
    for (int i = 0; i < DEPTH; i++) begin
      write_word(data_t'($random(seed)));
      check_count("count", model_count, count);
    end
    check_flag("write_ready", 1'b0, write_ready);
    check_flag("full", 1'b1, full);
  endtask

  // Stepping by an odd stride visits every slot of a power-of-two depth once
  task automatic test_out_of_order_reads();
    for (int i = 0; i < DEPTH; i++) begin
      read_slot(index_t'((i * 5 + 3) % DEPTH), 1'b0);
    end
    check_count("count", count_t'(DEPTH), count);
  endtask

  // The model expects slot 2 and then slot 5 from the two writes
  task automatic test_clear_reuse();
    read_slot(index_t'(5), 1'b1);
    read_slot(index_t'(2), 1'b1);
    check_count("count", count_t'(DEPTH - 2), count);
    write_word(data_t'($random(seed)));
    write_word(data_t'($random(seed)));
  endtask

  task automatic test_invalid_read();
    read_slot(index_t'(4), 1'b1);
    read_free_slot(index_t'(4));
    read_slot(index_t'(1), 1'b0);
    read_slot(index_t'(6), 1'b0);
    check_count("count", model_count, count);
  endtask

  task automatic test_flush();
    int busy_cycles;
    flush = 1'b1;
    @(posedge clock);
    #1;
    flush = 1'b0;
    #1;
    busy_cycles = 0;
    while (flush_busy && busy_cycles < TIMEOUT_CYCLES) begin
      check_flag("write_ready", 1'b0, write_ready);
      check_flag("read_ready", 1'b0, read_ready);
      busy_cycles++;
      @(posedge clock);
      #2;
    end
    if (flush_busy) begin
      $display("Timeout: flush_busy stayed high at %0t", $time);
      timeout_count++;
    end
    check_count("flush_busy cycles", count_t'(DEPTH), count_t'(busy_cycles));
    @(posedge clock);
    #1;
    for (int i = 0; i < DEPTH; i++) begin
      model_valid[i] = 1'b0;
    end
    model_count = '0;
    check_count("count", model_count, count);
    check_flag("empty", 1'b1, empty);
    for (int i = 0; i < DEPTH; i++) begin
      read_free_slot(index_t'(i));
    end
  endtask

  task automatic test_random_mix();
    int     op;
    index_t idx;
    data_t  value;
    for (int n = 0; n < 200; n++) begin
      op    = {$random(seed)} % 4;
      idx   = index_t'($random(seed));
      value = data_t'($random(seed));
      if (op < 2 && model_count != count_t'(DEPTH)) begin
        write_word(value);
      end else if (op == 3 && model_valid[idx] && model_count != count_t'(DEPTH)) begin
        write_and_clear(value, idx);
      end else if (model_valid[idx]) begin
        read_slot(idx, op[0]);
      end else begin
        read_free_slot(idx);
      end
      check_count("count", model_count, count);
      check_flag("full", model_count == count_t'(DEPTH), full);
      check_flag("empty", model_count == '0, empty);
    end
  endtask

  initial begin
    seed           = 87;
    mismatch_count = 0;
    timeout_count  = 0;
    rst            = 1'b1;
    write_valid    = 1'b0;
    write_data     = '0;
    read_valid     = 1'b0;
    read_clear     = 1'b0;
    read_index     = '0;
    flush          = 1'b0;
    model_count    = '0;
    for (int i = 0; i < DEPTH; i++) begin
      model_valid[i] = 1'b0;
      model_data[i]  = '0;
    end
    repeat (10) @(posedge clock);
    #1;
    rst = 1'b0;
    check_count("count", '0, count);
    check_flag("empty", 1'b1, empty);
    check_flag("full", 1'b0, full);
    check_flag("flush_busy", 1'b0, flush_busy);
    test_fill();
    test_out_of_order_reads();
    test_clear_reuse();
    test_invalid_read();
    test_flush();
    test_random_mix();
    $display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
    if (mismatch_count == 0 && timeout_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: ooo_buffer.f
rtl/ooo_buffer_pkg.sv
rtl/ooo_ctrl_pkg.sv
rtl/ooo_slot_if.sv
rtl/out_of_order_buffer.sv
rtl/valid_ready_out_of_order_buffer.sv
rtl/occupancy_counter.sv
rtl/flush_controller.sv
rtl/ooo_buffer_top.sv
testbench/ooo_buffer_tb.sv
